// File: mbcControl.f
source/mbcBusPkg.sv
source/mbcCtrlPkg.sv
source/mbcPhaseClock.sv
source/mbcRequestLatch.sv
source/mbcMemStart.sv
source/mbcCoreRead.sv
source/mbcControl.sv
verif/mbcControlTb.sv

// File: source/mbcBusPkg.sv
// Memory bus widths and field types, referenced by scoped name from the control RTL.
package mbcBusPkg;

  // A memory block holds four words.
  parameter int wordCount = 4;

  // Width of a word address within one block.
  parameter int wordAdrWidth = $clog2(wordCount);

  // One request bit per word of the block.
  typedef logic [wordCount-1:0] wordMaskT;

  // Word address within the block. It wraps from the top word back to word 0.
  typedef logic [wordAdrWidth-1:0] wordAdrT;

  // The two memory clock phases. Phase A runs first after reset.
  typedef enum logic {
    phaseA = 1'b0,
    phaseB = 1'b1
  } phaseT;

endpackage

// File: source/mbcControl.sv
// Top level of the memory request control that wires the phase clock, latch, tracker and pipeline.
`timescale 1ns/100ps

module mbcControl #(
  parameter int phaseLen    = 2,
  parameter bit forceBadPar = 1'b0
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 rqStrobe,
  input  mbcBusPkg::wordMaskT  rqMask,
  input  mbcCtrlPkg::rqKindT   rqKind,
  input  mbcBusPkg::wordAdrT   rqAdr,
  input  logic                 memAck,
  output mbcBusPkg::phaseT     phase,
  output logic                 memStart,
  output mbcBusPkg::phaseT     startPhase,
  output logic                 busy,
  output mbcBusPkg::wordMaskT  memRq,
  output logic                 memRead,
  output logic                 memWrite,
  output logic                 memAdrPar,
  output logic                 coreDataValid,
  output mbcBusPkg::wordAdrT   coreAdr,
  output logic                 coreRdInProg
);

  logic                aChange;
  logic                bChange;
  logic                held;
  logic                releasePulse;
  mbcBusPkg::wordMaskT heldMask;
  mbcCtrlPkg::rqKindT  heldKind;
  mbcBusPkg::wordAdrT  heldAdr;
  logic                ackPulse;
  mbcBusPkg::wordAdrT  ackWord;
  logic                ackLast;

  mbcPhaseClock #(.phaseLen(phaseLen)) phaseClock_i (
    .clk(clk), .rstN(rstN), .phase(phase), .aChange(aChange), .bChange(bChange)
  );

  mbcRequestLatch #(.forceBadPar(forceBadPar)) requestLatch_i (
    .clk(clk), .rstN(rstN),
    .rqStrobe(rqStrobe), .rqMask(rqMask), .rqKind(rqKind), .rqAdr(rqAdr),
    .busy(busy), .releasePulse(releasePulse),
    .held(held), .heldMask(heldMask), .heldKind(heldKind), .heldAdr(heldAdr),
    .memRq(memRq), .memRead(memRead), .memWrite(memWrite), .memAdrPar(memAdrPar)
  );

  mbcMemStart memStart_i (
    .clk(clk), .rstN(rstN), .aChange(aChange), .bChange(bChange),
    .held(held), .heldMask(heldMask), .heldAdr(heldAdr), .memAck(memAck),
    .busy(busy), .releasePulse(releasePulse), .memStart(memStart), .startPhase(startPhase),
    .ackPulse(ackPulse), .ackWord(ackWord), .ackLast(ackLast)
  );

  mbcCoreRead coreRead_i (
    .clk(clk), .rstN(rstN), .memStart(memStart), .heldKind(heldKind),
    .ackPulse(ackPulse), .ackWord(ackWord), .ackLast(ackLast),
    .coreDataValid(coreDataValid), .coreAdr(coreAdr), .coreRdInProg(coreRdInProg)
  );

endmodule

// File: source/mbcCoreRead.sv
// Core-read pipeline that reports each acknowledged read word two cycles later with its address.
`timescale 1ns/100ps

module mbcCoreRead (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 memStart,
  input  mbcCtrlPkg::rqKindT   heldKind,
  input  logic                 ackPulse,
  input  mbcBusPkg::wordAdrT   ackWord,
  input  logic                 ackLast,
  output logic                 coreDataValid,
  output mbcBusPkg::wordAdrT   coreAdr,
  output logic                 coreRdInProg
);

  logic               isRead;
  logic               memStartQ;
  logic               startRise;
  logic               startFall;
  logic               ackSeen;
  logic               s1Valid;
  logic               s1Last;
  logic               s2Valid;
  logic               s2Last;
  mbcBusPkg::wordAdrT s1Word;
  mbcBusPkg::wordAdrT s2Word;

  assign isRead    = (heldKind == mbcCtrlPkg::rqRead);
  assign startRise = memStart && !memStartQ;
  assign startFall = !memStart && memStartQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memStartQ <= 1'b0;
      ackSeen   <= 1'b0;
      s1Valid   <= 1'b0;
      s1Last    <= 1'b0;
      s2Valid   <= 1'b0;
      s2Last    <= 1'b0;
    end else begin
      memStartQ <= memStart;
      if (!memStart) begin
        ackSeen <= 1'b0;
      end else if (ackPulse) begin
        ackSeen <= 1'b1;
      end
      // Write acknowledges never enter the pipeline.
      s1Valid <= ackPulse && isRead;
      s1Last  <= ackLast && isRead;
      s2Valid <= s1Valid;
      s2Last  <= s1Last;
    end
  end

  always_ff @(posedge clk) begin
    s1Word <= ackWord;
    s2Word <= s1Word;
  end

  // A read with an empty mask ends without any word, so its fall clears the flag.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      coreRdInProg <= 1'b0;
    end else if (startRise && isRead) begin
      coreRdInProg <= 1'b1;
    end else if ((s2Valid && s2Last) || (startFall && !ackSeen)) begin
      coreRdInProg <= 1'b0;
    end
  end

  assign coreDataValid = s2Valid;
  assign coreAdr       = s2Word;

endmodule

// File: source/mbcCtrlPkg.sv
// Control state and request-kind encodings for the memory start logic and request latch.
package mbcCtrlPkg;

  // A start is tied to the phase on which it began.
  typedef enum logic [1:0] {
    startIdle = 2'b00,
    startOnA  = 2'b01,
    startOnB  = 2'b10
  } startStateT;

  // Kind of memory request held in the latch.
  typedef enum logic {
    rqRead  = 1'b0,
    rqWrite = 1'b1
  } rqKindT;

endpackage

// File: source/mbcMemStart.sv
// Memory start tracker that owns a phase for each start and counts acknowledges word by word.
`timescale 1ns/100ps

module mbcMemStart (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 aChange,
  input  logic                 bChange,
  input  logic                 held,
  input  mbcBusPkg::wordMaskT  heldMask,
  input  mbcBusPkg::wordAdrT   heldAdr,
  input  logic                 memAck,
  output logic                 busy,
  output logic                 releasePulse,
  output logic                 memStart,
  output mbcBusPkg::phaseT     startPhase,
  output logic                 ackPulse,
  output mbcBusPkg::wordAdrT   ackWord,
  output logic                 ackLast
);

  mbcCtrlPkg::startStateT state;
  mbcBusPkg::wordMaskT    remaining;
  mbcBusPkg::wordMaskT    remainingNext;
  mbcBusPkg::wordAdrT     wordPtr;
  mbcBusPkg::wordAdrT     nextWord;
  logic                   ownStrobe;

  // Find the next requested word at or after the pointer, wrapping past the top word.
  always_comb begin : nextSearch
    mbcBusPkg::wordAdrT probe;
    logic found;
    nextWord = wordPtr;
    found    = 1'b0;
    for (int i = 0; i < mbcBusPkg::wordCount; i++) begin
      probe = wordPtr + mbcBusPkg::wordAdrT'(i);
      if (!found && remaining[probe]) begin
        nextWord = probe;
        found    = 1'b1;
      end
    end
  end

  assign remainingNext = remaining & ~(mbcBusPkg::wordMaskT'(1) << nextWord);

  // Acknowledges count only on the strobe of the phase that owns the start.
  assign ownStrobe = ((state == mbcCtrlPkg::startOnA) && aChange) ||
                     ((state == mbcCtrlPkg::startOnB) && bChange);

  assign ackPulse = ownStrobe && memAck && (remaining != '0);
  assign ackWord  = nextWord;
  assign ackLast  = ackPulse && (remainingNext == '0);

  // An empty mask ends on the first owning strobe without an acknowledge.
  assign releasePulse = ownStrobe && ((remaining == '0) || ackLast);

  assign memStart   = (state != mbcCtrlPkg::startIdle);
  assign busy       = memStart || held;
  assign startPhase = (state == mbcCtrlPkg::startOnB) ? mbcBusPkg::phaseB : mbcBusPkg::phaseA;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= mbcCtrlPkg::startIdle;
      remaining <= '0;
      wordPtr   <= '0;
    end else begin
      case (state)
        mbcCtrlPkg::startIdle: begin
          if (held && (aChange || bChange)) begin
            state     <= aChange ? mbcCtrlPkg::startOnA : mbcCtrlPkg::startOnB;
            remaining <= heldMask;
            wordPtr   <= heldAdr;
          end
        end
        default: begin
          if (releasePulse) begin
            state <= mbcCtrlPkg::startIdle;
          end
          if (ackPulse) begin
            remaining <= remainingNext;
            wordPtr   <= nextWord + mbcBusPkg::wordAdrT'(1);
          end
        end
      endcase
    end
  end

endmodule

// File: source/mbcPhaseClock.sv
// Two-phase memory clock that marks the last cycle of each A and B phase with a change strobe.
`timescale 1ns/100ps

module mbcPhaseClock #(
  parameter int phaseLen = 2
) (
  input  logic              clk,
  input  logic              rstN,
  output mbcBusPkg::phaseT  phase,
  output logic              aChange,
  output logic              bChange
);

  // Counter value of the last cycle in a phase.
  localparam logic [2:0] lastCnt = 3'(phaseLen - 1);

  logic [2:0] cycleCnt;
  logic       lastCycle;

  assign lastCycle = (cycleCnt == lastCnt);

  // The strobes come one cycle ahead of the phase flip.
  assign aChange = lastCycle && (phase == mbcBusPkg::phaseA);
  assign bChange = lastCycle && (phase == mbcBusPkg::phaseB);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycleCnt <= '0;
    end else if (lastCycle) begin
      cycleCnt <= '0;
    end else begin
      cycleCnt <= cycleCnt + 3'd1;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      phase <= mbcBusPkg::phaseA;
    end else if (lastCycle) begin
      if (phase == mbcBusPkg::phaseA) begin
        phase <= mbcBusPkg::phaseB;
      end else begin
        phase <= mbcBusPkg::phaseA;
      end
    end
  end

endmodule

// File: source/mbcRequestLatch.sv
// Request hold register that keeps one memory request and its parity until the start is released.
`timescale 1ns/100ps

module mbcRequestLatch #(
  parameter bit forceBadPar = 1'b0
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 rqStrobe,
  input  mbcBusPkg::wordMaskT  rqMask,
  input  mbcCtrlPkg::rqKindT   rqKind,
  input  mbcBusPkg::wordAdrT   rqAdr,
  input  logic                 busy,
  input  logic                 releasePulse,
  output logic                 held,
  output mbcBusPkg::wordMaskT  heldMask,
  output mbcCtrlPkg::rqKindT   heldKind,
  output mbcBusPkg::wordAdrT   heldAdr,
  output mbcBusPkg::wordMaskT  memRq,
  output logic                 memRead,
  output logic                 memWrite,
  output logic                 memAdrPar
);

  logic accept;
  logic rdFlag;
  logic wrFlag;
  logic parIn;
  logic parHeld;

  // Strobes that arrive while busy are dropped; there is no back-pressure.
  assign accept = rqStrobe && !busy;

  assign rdFlag = (rqKind == mbcCtrlPkg::rqRead);
  assign wrFlag = (rqKind == mbcCtrlPkg::rqWrite);

  // Parity covers the mask, both kind flags and the word address.
  assign parIn = (^rqMask) ^ rdFlag ^ wrFlag ^ (^rqAdr) ^ forceBadPar;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      held <= 1'b0;
    end else if (releasePulse) begin
      held <= 1'b0;
    end else if (accept) begin
      held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      heldMask <= rqMask;
      heldKind <= rqKind;
      heldAdr  <= rqAdr;
      parHeld  <= parIn;
    end
  end

  assign memRq     = heldMask;
  assign memAdrPar = parHeld;

  // The kind lines are only asserted while a request is pending.
  assign memRead  = held && (heldKind == mbcCtrlPkg::rqRead);
  assign memWrite = held && (heldKind == mbcCtrlPkg::rqWrite);

endmodule

// File: verif/mbcControlTb.sv
// Directed testbench for the memory request control; compile with the file list and run mbcControlTb.
`timescale 1ns/100ps

module mbcControlTb;

  localparam int phaseLen     = 2;
  localparam bit forceBadPar  = 1'b0;
  localparam int cycleLimit   = 4000;
  localparam int requestLimit = 200;

  logic                clk;
  logic                rstN;
  logic                rqStrobe;
  mbcBusPkg::wordMaskT rqMask;
  mbcCtrlPkg::rqKindT  rqKind;
  mbcBusPkg::wordAdrT  rqAdr;
  logic                memAck;
  mbcBusPkg::phaseT    phase;
  logic                memStart;
  mbcBusPkg::phaseT    startPhase;
  logic                busy;
  mbcBusPkg::wordMaskT memRq;
  logic                memRead;
  logic                memWrite;
  logic                memAdrPar;
  logic                coreDataValid;
  mbcBusPkg::wordAdrT  coreAdr;
  logic                coreRdInProg;

  int               mismatches = 0;
  int               failures   = 0;
  int               cycleCount = 0;
  int               modelCnt   = 0;
  mbcBusPkg::phaseT modelPhase = mbcBusPkg::phaseA;

  mbcControl #(.phaseLen(phaseLen), .forceBadPar(forceBadPar)) dut_i (
    .clk(clk), .rstN(rstN),
    .rqStrobe(rqStrobe), .rqMask(rqMask), .rqKind(rqKind), .rqAdr(rqAdr), .memAck(memAck),
    .phase(phase), .memStart(memStart), .startPhase(startPhase), .busy(busy),
    .memRq(memRq), .memRead(memRead), .memWrite(memWrite), .memAdrPar(memAdrPar),
    .coreDataValid(coreDataValid), .coreAdr(coreAdr), .coreRdInProg(coreRdInProg)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reference phase model. Phase A comes first and each phase lasts phaseLen cycles.
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      modelCnt   <= 0;
      modelPhase <= mbcBusPkg::phaseA;
    end else if (modelCnt == phaseLen - 1) begin
      modelCnt   <= 0;
      modelPhase <= (modelPhase == mbcBusPkg::phaseA) ? mbcBusPkg::phaseB : mbcBusPkg::phaseA;
    end else begin
      modelCnt <= modelCnt + 1;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not end within %0d cycles", cycleLimit);
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // True in the last cycle of either phase.
  function automatic logic modelStrobe();
    return modelCnt == phaseLen - 1;
  endfunction

  function automatic logic expectedParity(input mbcBusPkg::wordMaskT mask,
                                          input mbcCtrlPkg::rqKindT kind,
                                          input mbcBusPkg::wordAdrT adr);
    logic p;
    p = forceBadPar;
    for (int i = 0; i < 4; i++) begin
      p = p ^ mask[i];
    end
    p = p ^ (kind == mbcCtrlPkg::rqRead) ^ (kind == mbcCtrlPkg::rqWrite);
    p = p ^ adr[0] ^ adr[1];
    return p;
  endfunction

  task automatic reportMismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    mismatches++;
    $display("MISMATCH %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic checkIdle();
    if (phase !== modelPhase) reportMismatch("phase", phase, modelPhase);
    if (memStart !== 1'b0) reportMismatch("memStart while idle", memStart, 0);
    if (busy !== 1'b0) reportMismatch("busy while idle", busy, 0);
    if (memRead !== 1'b0) reportMismatch("memRead while idle", memRead, 0);
    if (memWrite !== 1'b0) reportMismatch("memWrite while idle", memWrite, 0);
    if (coreDataValid !== 1'b0) reportMismatch("coreDataValid while idle", coreDataValid, 0);
    if (coreRdInProg !== 1'b0) reportMismatch("coreRdInProg while idle", coreRdInProg, 0);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      nextCycle();
      rqStrobe = 1'b0;
      memAck   = 1'($urandom_range(1));
      @(negedge clk);
      checkIdle();
    end
  endtask

  // Issues one request and follows it cycle by cycle until its last word has left the pipeline.
  task automatic runRequest(input mbcCtrlPkg::rqKindT kind, input mbcBusPkg::wordMaskT mask,
                            input mbcBusPkg::wordAdrT adr, input bit injectBusy);
    mbcBusPkg::wordAdrT words[$];
    mbcBusPkg::wordAdrT dueWord[$];
    int                 due[$];
    mbcBusPkg::wordAdrT w;
    mbcBusPkg::phaseT   ownPhase;
    logic               parity;
    logic               heldExp;
    logic               startExp;
    logic               startNext;
    logic               endNext;
    logic               owning;
    logic               ackNow;
    int                 cyc;
    bit                 done;
    for (int i = 0; i < 4; i++) begin
      w = adr + mbcBusPkg::wordAdrT'(i);
      if (mask[w]) words.push_back(w);
    end
    parity   = expectedParity(mask, kind, adr);
    ownPhase = mbcBusPkg::phaseA;
    nextCycle();
    rqStrobe = 1'b1;
    rqMask   = mask;
    rqKind   = kind;
    rqAdr    = adr;
    memAck   = 1'b0;
    @(negedge clk);
    heldExp   = 1'b1;
    startExp  = 1'b0;
    startNext = 1'b0;
    endNext   = 1'b0;
    cyc       = 0;
    done      = 1'b0;
    while (!done && cyc < requestLimit) begin
      nextCycle();
      cyc++;
      rqStrobe = 1'b0;
      if (startNext) begin
        startExp  = 1'b1;
        startNext = 1'b0;
      end
      if (endNext) begin
        startExp = 1'b0;
        heldExp  = 1'b0;
        endNext  = 1'b0;
      end
      // Acks on the other phase are always offered and must be ignored.
      owning = startExp && modelStrobe() && (modelPhase == ownPhase);
      ackNow = owning ? ($urandom_range(3) != 0) : 1'b1;
      memAck = ackNow;
      if (injectBusy && cyc == 2) begin
        rqStrobe = 1'b1;
        rqMask   = ~mask;
        rqAdr    = adr + 2'd1;
      end
      if (owning) begin
        if (words.size() == 0) begin
          endNext = 1'b1;
        end else if (ackNow) begin
          w = words.pop_front();
          if (kind == mbcCtrlPkg::rqRead) begin
            due.push_back(cyc + 2);
            dueWord.push_back(w);
          end
          if (words.size() == 0) endNext = 1'b1;
        end
      end else if (heldExp && !startExp && modelStrobe()) begin
        startNext = 1'b1;
        ownPhase  = modelPhase;
      end
      @(negedge clk);
      if (phase !== modelPhase) reportMismatch("phase", phase, modelPhase);
      if (memStart !== startExp) reportMismatch("memStart", memStart, startExp);
      if (busy !== heldExp) reportMismatch("busy", busy, heldExp);
      if (startExp && startPhase !== ownPhase) reportMismatch("startPhase", startPhase, ownPhase);
      if (heldExp) begin
        if (memRq !== mask) reportMismatch("memRq", memRq, mask);
        if (memAdrPar !== parity) reportMismatch("memAdrPar", memAdrPar, parity);
        if (memRead !== (kind == mbcCtrlPkg::rqRead)) reportMismatch("memRead", memRead, !kind);
        if (memWrite !== (kind == mbcCtrlPkg::rqWrite)) reportMismatch("memWrite", memWrite, kind);
      end
      if (due.size() > 0 && due[0] == cyc) begin
        if (coreDataValid !== 1'b1) reportMismatch("coreDataValid", coreDataValid, 1);
        if (coreAdr !== dueWord[0]) reportMismatch("coreAdr", coreAdr, dueWord[0]);
        if (coreRdInProg !== 1'b1) reportMismatch("coreRdInProg", coreRdInProg, 1);
        void'(due.pop_front());
        void'(dueWord.pop_front());
      end else if (coreDataValid !== 1'b0) begin
        reportMismatch("coreDataValid", coreDataValid, 0);
      end
      done = !heldExp && (due.size() == 0);
    end
    if (!done) begin
      failures++;
      $display("Request did not finish within %0d cycles", requestLimit);
    end
    idleCycles(2);
  endtask

  task automatic testPhaseClock();
    mbcBusPkg::phaseT prevPhase;
    int               runLen;
    bit               seenFlip;
    prevPhase = phase;
    runLen    = 0;
    seenFlip  = 1'b0;
    repeat (8 * phaseLen) begin
      nextCycle();
      @(negedge clk);
      checkIdle();
      if (phase != prevPhase) begin
        if (seenFlip && runLen != phaseLen) reportMismatch("phase run length", runLen, phaseLen);
        seenFlip = 1'b1;
        runLen   = 1;
      end else begin
        runLen++;
      end
      prevPhase = phase;
    end
  endtask

  task automatic testWriteHold();
    runRequest(mbcCtrlPkg::rqWrite, 4'b1011, 2'd2, 1'b0);
    runRequest(mbcCtrlPkg::rqWrite, mbcBusPkg::wordMaskT'($urandom_range(15)),
               mbcBusPkg::wordAdrT'($urandom_range(3)), 1'b0);
  endtask

  // Random idle gaps move the strobe so that starts land on both phases.
  task automatic testStartPhase();
    repeat (8) begin
      idleCycles($urandom_range(3));
      runRequest($urandom_range(1) ? mbcCtrlPkg::rqWrite : mbcCtrlPkg::rqRead,
                 mbcBusPkg::wordMaskT'($urandom_range(15)),
                 mbcBusPkg::wordAdrT'($urandom_range(3)), 1'b0);
    end
  endtask

  task automatic testCoreReadOrder();
    repeat (20) begin
      idleCycles($urandom_range(2));
      runRequest(mbcCtrlPkg::rqRead, mbcBusPkg::wordMaskT'($urandom_range(15)),
                 mbcBusPkg::wordAdrT'($urandom_range(3)), 1'b0);
    end
  endtask

  task automatic testBusyAndEmpty();
    runRequest(mbcCtrlPkg::rqRead, 4'b0110, 2'd3, 1'b1);
    runRequest(mbcCtrlPkg::rqWrite, 4'b1001, 2'd1, 1'b1);
    runRequest(mbcCtrlPkg::rqRead, 4'b0000, 2'd1, 1'b0);
    runRequest(mbcCtrlPkg::rqWrite, 4'b0000, 2'd0, 1'b0);
  endtask

  initial begin
    int seedDummy;
    seedDummy = $urandom(32'hc8e1);
    rstN      = 1'b0;
    rqStrobe  = 1'b0;
    rqMask    = '0;
    rqKind    = mbcCtrlPkg::rqRead;
    rqAdr     = '0;
    memAck    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;
    testPhaseClock();
    testWriteHold();
    testStartPhase();
    testCoreReadOrder();
    testBusyAndEmpty();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
